/* design/fu_pkg.sv */
package fu_pkg;

    // datapath widths
    localparam int xlen   = 32;
    localparam int robn_w = 5;  // reorder buffer tag
    localparam int prn_w  = 6;  // physical register number

    // alu operation select
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_e;

    // operand a source
    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_pc   = 2'h1,
        opa_is_zero = 2'h2
    } opa_select_e;

    // operand b source, rs2 or one of the sign-extended immediates
    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_select_e;

    // conditional branch type, same encoding as funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_func_e;

    // fill patterns, easy to spot in waves
    localparam logic [xlen-1:0] bad_operand = 32'hdeadface;
    localparam logic [xlen-1:0] bad_result  = 32'hfacebeec;

endpackage

/* design/fu_operand_select.sv */
`timescale 1ns/1ps

module fu_operand_select #(
    parameter int num_lanes = 2
) (
    input  logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] inst,
    input  logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] pc,
    input  logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] op1,
    input  logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] op2,
    input  fu_pkg::opa_select_e   [num_lanes-1:0]                   opa_select,
    input  fu_pkg::opb_select_e   [num_lanes-1:0]                   opb_select,

    output logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] opa,
    output logic                  [num_lanes-1:0][fu_pkg::xlen-1:0] opb
);

    // rv32 immediate decode, all sign extended from bit 31
    function automatic logic [fu_pkg::xlen-1:0] imm_i(input logic [fu_pkg::xlen-1:0] ins);
        return {{20{ins[31]}}, ins[31:20]};
    endfunction

    function automatic logic [fu_pkg::xlen-1:0] imm_s(input logic [fu_pkg::xlen-1:0] ins);
        return {{20{ins[31]}}, ins[31:25], ins[11:7]};
    endfunction

    function automatic logic [fu_pkg::xlen-1:0] imm_b(input logic [fu_pkg::xlen-1:0] ins);
        return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

    function automatic logic [fu_pkg::xlen-1:0] imm_u(input logic [fu_pkg::xlen-1:0] ins);
        return {ins[31:12], 12'b0};  // upper 20 bits, low half zero
    endfunction

    function automatic logic [fu_pkg::xlen-1:0] imm_j(input logic [fu_pkg::xlen-1:0] ins);
        return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    endfunction

    // operand a mux
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            case (opa_select[i])
                fu_pkg::opa_is_rs1:  opa[i] = op1[i];
                fu_pkg::opa_is_pc:   opa[i] = pc[i];
                fu_pkg::opa_is_zero: opa[i] = '0;
                default:             opa[i] = fu_pkg::bad_operand;
            endcase
        end
    end

    // operand b mux
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            case (opb_select[i])
                fu_pkg::opb_is_rs2:   opb[i] = op2[i];
                fu_pkg::opb_is_i_imm: opb[i] = imm_i(inst[i]);
                fu_pkg::opb_is_s_imm: opb[i] = imm_s(inst[i]);  // stores
                fu_pkg::opb_is_b_imm: opb[i] = imm_b(inst[i]);  // branch offset
                fu_pkg::opb_is_u_imm: opb[i] = imm_u(inst[i]);  // lui, auipc
                fu_pkg::opb_is_j_imm: opb[i] = imm_j(inst[i]);  // jal offset
                default:              opb[i] = fu_pkg::bad_operand;
            endcase
        end
    end

endmodule

/* design/alu_lane.sv */
`timescale 1ns/1ps

module alu_lane (
    input  logic [fu_pkg::xlen-1:0] opa,
    input  logic [fu_pkg::xlen-1:0] opb,
    input  logic [fu_pkg::xlen-1:0] op1,   // raw rs1, for branch compare
    input  logic [fu_pkg::xlen-1:0] op2,   // raw rs2
    input  logic [fu_pkg::xlen-1:0] inst,
    input  fu_pkg::alu_func_e       func,

    output logic [fu_pkg::xlen-1:0] result,
    output logic                    take
);

    logic signed [fu_pkg::xlen-1:0] signed_opa;
    logic signed [fu_pkg::xlen-1:0] signed_opb;
    logic signed [fu_pkg::xlen-1:0] signed_op1;
    logic signed [fu_pkg::xlen-1:0] signed_op2;
    logic        [4:0]              shamt;
    fu_pkg::branch_func_e           br_func;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign signed_op1 = op1;
    assign signed_op2 = op2;
    assign shamt      = opb[4:0];  // rv32 shifts use 5 bits only

    // funct3 picks the branch condition
    assign br_func = fu_pkg::branch_func_e'(inst[14:12]);

    always_comb begin
        case (func)
            fu_pkg::alu_add:  result = opa + opb;
            fu_pkg::alu_sub:  result = opa - opb;
            fu_pkg::alu_and:  result = opa & opb;
            fu_pkg::alu_or:   result = opa | opb;
            fu_pkg::alu_xor:  result = opa ^ opb;
            fu_pkg::alu_slt:  result = {{(fu_pkg::xlen-1){1'b0}}, signed_opa < signed_opb};
            fu_pkg::alu_sltu: result = {{(fu_pkg::xlen-1){1'b0}}, opa < opb};
            fu_pkg::alu_sll:  result = opa << shamt;
            fu_pkg::alu_srl:  result = opa >> shamt;
            fu_pkg::alu_sra:  result = signed_opa >>> shamt;  // keeps sign bit
            default:          result = fu_pkg::bad_result;
        endcase
    end

    // branch condition on the register values, not the muxed operands
    always_comb begin
        case (br_func)
            fu_pkg::br_beq:  take = op1 == op2;
            fu_pkg::br_bne:  take = op1 != op2;
            fu_pkg::br_blt:  take = signed_op1 <  signed_op2;
            fu_pkg::br_bge:  take = signed_op1 >= signed_op2;
            fu_pkg::br_bltu: take = op1 <  op2;
            fu_pkg::br_bgeu: take = op1 >= op2;
            default:         take = 1'b0;  // funct3 010, 011 not branches
        endcase
    end

endmodule

/* design/fu_result_stage.sv */
`timescale 1ns/1ps

module fu_result_stage #(
    parameter int num_lanes = 2
) (
    input  logic clock,
    input  logic reset,

    input  logic [num_lanes-1:0]                     valid,
    input  logic [num_lanes-1:0]                     cond_branch,
    input  logic [num_lanes-1:0]                     uncond_branch,
    input  logic [num_lanes-1:0][fu_pkg::robn_w-1:0] robn,
    input  logic [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn,
    input  logic [num_lanes-1:0][fu_pkg::xlen-1:0]   result,
    input  logic [num_lanes-1:0]                     take,

    output logic [num_lanes-1:0]                     done,
    output logic [num_lanes-1:0][fu_pkg::xlen-1:0]   result_out,
    output logic [num_lanes-1:0][fu_pkg::robn_w-1:0] robn_out,
    output logic [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn_out,
    output logic [num_lanes-1:0]                     take_branch,
    output logic [num_lanes-1:0]                     branch_resolved
);

    logic [num_lanes-1:0] take_next;
    logic [num_lanes-1:0] resolved_next;

    // jumps always redirect, branches only when the compare holds
    assign take_next     = valid & (uncond_branch | (cond_branch & take));
    // rob only waits on conditional branches
    assign resolved_next = valid & cond_branch;

    always_ff @(posedge clock) begin
        if (reset) begin
            done            <= '0;
            take_branch     <= '0;
            branch_resolved <= '0;
        end else begin
            done            <= valid;
            take_branch     <= take_next;
            branch_resolved <= resolved_next;
        end
    end

    // payload, qualified by done
    always_ff @(posedge clock) begin
        result_out   <= result;  // also the target address for jumps
        robn_out     <= robn;
        dest_prn_out <= dest_prn;
    end

endmodule

/* design/fu_alu_cluster.sv */
`timescale 1ns/1ps

module fu_alu_cluster #(
    parameter int num_lanes = 2
) (
    input  logic clock,
    input  logic reset,

    input  logic                [num_lanes-1:0]                     valid,
    input  logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   inst,
    input  logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   pc,
    input  logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   op1,
    input  logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   op2,
    input  fu_pkg::alu_func_e   [num_lanes-1:0]                     func,
    input  fu_pkg::opa_select_e [num_lanes-1:0]                     opa_select,
    input  fu_pkg::opb_select_e [num_lanes-1:0]                     opb_select,
    input  logic                [num_lanes-1:0]                     cond_branch,
    input  logic                [num_lanes-1:0]                     uncond_branch,
    input  logic                [num_lanes-1:0][fu_pkg::robn_w-1:0] robn,
    input  logic                [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn,

    output logic                [num_lanes-1:0]                     done,
    output logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   result_out,
    output logic                [num_lanes-1:0][fu_pkg::robn_w-1:0] robn_out,
    output logic                [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn_out,
    output logic                [num_lanes-1:0]                     take_branch,
    output logic                [num_lanes-1:0]                     branch_resolved
);

    logic [num_lanes-1:0][fu_pkg::xlen-1:0] opa;
    logic [num_lanes-1:0][fu_pkg::xlen-1:0] opb;
    logic [num_lanes-1:0][fu_pkg::xlen-1:0] result;
    logic [num_lanes-1:0]                   take;

    fu_operand_select #(
        .num_lanes(num_lanes)
    ) operand_select_i (
        .inst(inst),
        .pc(pc),
        .op1(op1),
        .op2(op2),
        .opa_select(opa_select),
        .opb_select(opb_select),
        .opa(opa),
        .opb(opb)
    );

    // one single-cycle alu per lane
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        alu_lane alu_lane_i (
            .opa(opa[g]),
            .opb(opb[g]),
            .op1(op1[g]),
            .op2(op2[g]),
            .inst(inst[g]),
            .func(func[g]),
            .result(result[g]),
            .take(take[g])
        );
    end

    fu_result_stage #(
        .num_lanes(num_lanes)
    ) result_stage_i (
        .clock(clock),
        .reset(reset),
        .valid(valid),
        .cond_branch(cond_branch),
        .uncond_branch(uncond_branch),
        .robn(robn),
        .dest_prn(dest_prn),
        .result(result),
        .take(take),
        .done(done),
        .result_out(result_out),
        .robn_out(robn_out),
        .dest_prn_out(dest_prn_out),
        .take_branch(take_branch),
        .branch_resolved(branch_resolved)
    );

endmodule

/* verif/fu_alu_cluster_tb.sv */
`timescale 1ns/1ps

module fu_alu_cluster_tb;

    localparam int num_lanes   = 2;
    localparam int max_vectors = 64;
    localparam int max_cycles  = 400;  // whole vector run
    localparam int reset_limit = 20;

    logic clock;
    logic reset;

    logic                [num_lanes-1:0]                     valid;
    logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   inst;
    logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   pc;
    logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   op1;
    logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   op2;
    fu_pkg::alu_func_e   [num_lanes-1:0]                     func;
    fu_pkg::opa_select_e [num_lanes-1:0]                     opa_select;
    fu_pkg::opb_select_e [num_lanes-1:0]                     opb_select;
    logic                [num_lanes-1:0]                     cond_branch;
    logic                [num_lanes-1:0]                     uncond_branch;
    logic                [num_lanes-1:0][fu_pkg::robn_w-1:0] robn;
    logic                [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn;

    logic                [num_lanes-1:0]                     done;
    logic                [num_lanes-1:0][fu_pkg::xlen-1:0]   result_out;
    logic                [num_lanes-1:0][fu_pkg::robn_w-1:0] robn_out;
    logic                [num_lanes-1:0][fu_pkg::prn_w-1:0]  dest_prn_out;
    logic                [num_lanes-1:0]                     take_branch;
    logic                [num_lanes-1:0]                     branch_resolved;

    // pattern file columns, one entry per line
    logic [31:0] vec_lane   [max_vectors];
    logic [31:0] vec_func   [max_vectors];
    logic [31:0] vec_opa    [max_vectors];
    logic [31:0] vec_opb    [max_vectors];
    logic [31:0] vec_inst   [max_vectors];
    logic [31:0] vec_pc     [max_vectors];
    logic [31:0] vec_op1    [max_vectors];
    logic [31:0] vec_op2    [max_vectors];
    logic [31:0] vec_cond   [max_vectors];
    logic [31:0] vec_uncond [max_vectors];
    logic [31:0] vec_robn   [max_vectors];
    logic [31:0] vec_prn    [max_vectors];
    logic [31:0] vec_res    [max_vectors];
    logic [31:0] vec_take   [max_vectors];
    int          num_vectors;

    // what each lane should report after the next register edge
    logic [num_lanes-1:0]      exp_active;
    logic [num_lanes-1:0]      exp_take;
    logic [num_lanes-1:0]      exp_resolved;
    logic [fu_pkg::xlen-1:0]   exp_result [num_lanes];
    logic [fu_pkg::robn_w-1:0] exp_robn   [num_lanes];
    logic [fu_pkg::prn_w-1:0]  exp_prn    [num_lanes];

    integer seed;

    fu_alu_cluster #(
        .num_lanes(num_lanes)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .valid(valid),
        .inst(inst),
        .pc(pc),
        .op1(op1),
        .op2(op2),
        .func(func),
        .opa_select(opa_select),
        .opb_select(opb_select),
        .cond_branch(cond_branch),
        .uncond_branch(uncond_branch),
        .robn(robn),
        .dest_prn(dest_prn),
        .done(done),
        .result_out(result_out),
        .robn_out(robn_out),
        .dest_prn_out(dest_prn_out),
        .take_branch(take_branch),
        .branch_resolved(branch_resolved)
    );

    always #50 clock = ~clock;  // 100 ns period

    // release after four rising edges
    initial begin
        repeat (4) @(posedge clock);
        reset         <= 1'b0;
        valid         <= '0;  // ops offered under reset are dropped
        cond_branch   <= '0;
        uncond_branch <= '0;
    end

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_result(input string name, input logic [fu_pkg::xlen-1:0] got,
                                input logic [fu_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_tag(input string name, input logic [fu_pkg::robn_w-1:0] got,
                             input logic [fu_pkg::robn_w-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_prn(input string name, input logic [fu_pkg::prn_w-1:0] got,
                             input logic [fu_pkg::prn_w-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    code;
        int    n;
        string line;
        fd = $fopen("verif/fu_alu_patterns.txt", "r");
        if (fd == 0) abort_run("could not open verif/fu_alu_patterns.txt");
        num_vectors = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            n = 0;
            if (code != 0)  // comment and blank lines give fewer fields
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            vec_lane[num_vectors], vec_func[num_vectors],
                            vec_opa[num_vectors], vec_opb[num_vectors],
                            vec_inst[num_vectors], vec_pc[num_vectors],
                            vec_op1[num_vectors], vec_op2[num_vectors],
                            vec_cond[num_vectors], vec_uncond[num_vectors],
                            vec_robn[num_vectors], vec_prn[num_vectors],
                            vec_res[num_vectors], vec_take[num_vectors]);
            if (n == 14) begin
                if (vec_lane[num_vectors] >= num_lanes) abort_run("pattern lane out of range");
                num_vectors++;
                if (num_vectors == max_vectors) abort_run("too many lines in pattern file");
            end
        end
        $fclose(fd);
        if (num_vectors == 0) abort_run("pattern file holds no vectors");
    endtask

    // puts one pattern line on its lane and records what should come back
    task automatic drive_vector(input int i);
        int l;
        l = vec_lane[i];
        valid[l]         <= 1'b1;
        inst[l]          <= vec_inst[i];
        pc[l]            <= vec_pc[i];
        op1[l]           <= vec_op1[i];
        op2[l]           <= vec_op2[i];
        func[l]          <= fu_pkg::alu_func_e'(vec_func[i][3:0]);
        opa_select[l]    <= fu_pkg::opa_select_e'(vec_opa[i][1:0]);
        opb_select[l]    <= fu_pkg::opb_select_e'(vec_opb[i][2:0]);
        cond_branch[l]   <= vec_cond[i][0];
        uncond_branch[l] <= vec_uncond[i][0];
        robn[l]          <= vec_robn[i][fu_pkg::robn_w-1:0];
        dest_prn[l]      <= vec_prn[i][fu_pkg::prn_w-1:0];
        exp_active[l]   = 1'b1;
        exp_take[l]     = vec_take[i][0];
        exp_resolved[l] = vec_cond[i][0];  // only conditional branches resolve
        exp_result[l]   = vec_res[i];
        exp_robn[l]     = vec_robn[i][fu_pkg::robn_w-1:0];
        exp_prn[l]      = vec_prn[i][fu_pkg::prn_w-1:0];
    endtask

    task automatic check_lanes();
        for (int l = 0; l < num_lanes; l++) begin
            check_flag($sformatf("done[%0d]", l), done[l], exp_active[l]);
            check_flag($sformatf("take_branch[%0d]", l), take_branch[l],
                       exp_active[l] & exp_take[l]);
            check_flag($sformatf("branch_resolved[%0d]", l), branch_resolved[l],
                       exp_active[l] & exp_resolved[l]);
            if (exp_active[l]) begin  // payload is only meaningful with done
                check_result($sformatf("result_out[%0d]", l), result_out[l], exp_result[l]);
                check_tag($sformatf("robn_out[%0d]", l), robn_out[l], exp_robn[l]);
                check_prn($sformatf("dest_prn_out[%0d]", l), dest_prn_out[l], exp_prn[l]);
            end
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (reset) begin
            @(negedge clock);
            check_lanes();  // flags stay low under reset
            waited++;
            if (waited > reset_limit) abort_run("reset was never released");
        end
    endtask

    initial begin
        int idx;
        int gap;
        int cycles;
        seed          = 32'hd5f71418;
        clock         = 1'b0;
        reset         = 1'b1;
        valid         = '1;  // busy lanes under reset, only reset keeps flags low
        inst          = '0;
        pc            = '0;
        op1           = '0;
        op2           = '0;
        cond_branch   = '1;
        uncond_branch = '1;
        robn          = '0;
        dest_prn      = '0;
        exp_active    = '0;
        exp_take      = '0;
        exp_resolved  = '0;
        for (int l = 0; l < num_lanes; l++) begin
            func[l]       = fu_pkg::alu_add;
            opa_select[l] = fu_pkg::opa_is_rs1;
            opb_select[l] = fu_pkg::opb_is_rs2;
        end

        load_patterns();
        wait_reset_release();

        idx    = 0;
        cycles = 0;
        while (idx < num_vectors) begin
            if (cycles > max_cycles) abort_run("pattern run did not finish in time");
            @(posedge clock);
            exp_active = '0;
            drive_vector(idx);
            // a following line for the other lane shares the cycle
            if (idx + 1 < num_vectors && vec_lane[idx + 1] != vec_lane[idx]) begin
                drive_vector(idx + 1);
                idx = idx + 2;
            end else begin
                idx = idx + 1;
            end
            @(posedge clock);
            valid <= '0;
            @(negedge clock);
            check_lanes();
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clock);
                exp_active = '0;  // idle cycle, nothing reported
                @(negedge clock);
                check_lanes();
            end
            cycles = cycles + 2 + gap;
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verif/fu_alu_patterns.txt */
# lane func opa_sel opb_sel inst pc op1 op2 cond uncond robn dest_prn exp_result exp_take
# all hex; func 0 add .. 9 sra, opa 0 rs1 1 pc 2 zero, opb 0 rs2 1 i 2 s 3 b 4 u 5 j
0 0 0 0 00000013 00000000 00000005 00000007 0 0 01 21 0000000c 0
1 1 0 0 00000013 00000000 00000005 00000007 0 0 02 22 fffffffe 0
0 2 0 0 00000013 00000000 f0f0f0f0 0ff00ff0 0 0 03 23 00f000f0 0
1 3 0 0 00000013 00000000 f0f0f0f0 0ff00ff0 0 0 04 24 fff0fff0 0
0 4 0 0 00000013 00000000 f0f0f0f0 0ff00ff0 0 0 05 25 ff00ff00 0
1 5 0 0 00000013 00000000 ffffffff 00000001 0 0 06 26 00000001 0
0 6 0 0 00000013 00000000 ffffffff 00000001 0 0 07 27 00000000 0
1 5 0 0 00000013 00000000 00000001 ffffffff 0 0 08 28 00000000 0
0 6 0 0 00000013 00000000 00000001 ffffffff 0 0 09 29 00000001 0
1 7 0 0 00000013 00000000 00000003 00000024 0 0 0a 2a 00000030 0
0 8 0 0 00000013 00000000 80000010 00000004 0 0 0b 2b 08000001 0
1 9 0 0 00000013 00000000 80000010 00000004 0 0 0c 2c f8000001 0
0 9 0 0 00000013 00000000 7ffffff0 00000004 0 0 0d 2d 07ffffff 0
1 0 1 4 12345017 00001000 00000000 00000000 0 0 0e 2e 12346000 0
0 0 2 1 fff00093 00000000 00000000 00000000 0 0 0f 2f ffffffff 0
1 0 0 2 fe112e23 00000000 00002000 00000000 0 0 10 30 00001ffc 0
0 0 0 3 00000863 00000000 00000100 00000000 0 0 11 31 00000110 0
1 0 0 5 ff1ff06f 00000000 00001000 00000000 0 1 12 32 00000ff0 1
0 0 1 3 00000863 00002000 00000005 00000005 1 0 13 33 00002010 1
1 0 1 3 00001863 00002000 00000005 00000005 1 0 14 34 00002010 0
0 0 1 3 00004863 00002000 ffffffff 00000001 1 0 15 35 00002010 1
1 0 1 3 00005863 00002000 ffffffff 00000001 1 0 16 36 00002010 0
0 0 1 3 00006863 00002000 ffffffff 00000001 1 0 17 37 00002010 0
1 0 1 3 00007863 00002000 ffffffff 00000001 1 0 18 38 00002010 1
0 0 1 3 00001863 00002100 00000005 00000006 1 0 19 39 00002110 1
1 0 0 1 00008067 00000000 00003004 00000000 0 1 1a 3a 00003004 1
0 0 0 0 00000013 00000000 00000003 00000003 0 0 1b 3b 00000006 0

/* filelist.f */
design/fu_pkg.sv
design/fu_operand_select.sv
design/alu_lane.sv
design/fu_result_stage.sv
design/fu_alu_cluster.sv
verif/fu_alu_cluster_tb.sv

/* Bender.yml */
package:
  name: fu_alu_cluster

sources:
  - files:
      - design/fu_pkg.sv
      - design/fu_operand_select.sv
      - design/alu_lane.sv
      - design/fu_result_stage.sv
      - design/fu_alu_cluster.sv
  - target: test
    files:
      - verif/fu_alu_cluster_tb.sv
